// ==== hw/relay_alu_pkg.sv ====
// Relay ALU shared types.
// Data word, function codes, destination select and controller states
// for the eight-bit relay computer arithmetic-logic section.

`default_nettype none

package relay_alu_pkg;

  parameter int WIDTH_DEFAULT = 8;

  typedef logic [WIDTH_DEFAULT-1:0] alu_byte_t; // One word on the relay bus.

  typedef enum logic [2:0] {
    FUNC_ADD = 3'b000,
    FUNC_INC = 3'b001,
    FUNC_AND = 3'b010,
    FUNC_OR  = 3'b011,
    FUNC_XOR = 3'b100,
    FUNC_NOT = 3'b101,
    FUNC_SHL = 3'b110,
    FUNC_CLR = 3'b111
  } alu_func_t;

  typedef enum logic {
    DEST_A = 1'b0,
    DEST_D = 1'b1
  } alu_dest_t;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    LOAD  = 2'b01,
    WRITE = 2'b10,
    DONE  = 2'b11
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/relay_alu_if.sv ====
// Relay ALU command interface.
// Carries the controller's strobes and steering to the datapath.

`timescale 1ns/1ps
`default_nettype none

interface relay_alu_if
  import relay_alu_pkg::*;
();

  logic      load_ops;     // Latch B and C.
  logic      write_result; // Write destination and flags.
  alu_func_t func;
  alu_dest_t dest_sel;
  logic      add_carry_in;
  logic      c_enable;     // Low forces the C operand to zero at the adder.

  modport ctrl (
    output load_ops,
    output write_result,
    output func,
    output dest_sel,
    output add_carry_in,
    output c_enable
  );

  modport datapath (
    input load_ops,
    input write_result,
    input func,
    input dest_sel,
    input add_carry_in,
    input c_enable
  );

endinterface

`default_nettype wire

// ==== hw/relay_adder.sv ====
// Relay ripple-carry adder.
// One full-adder cell per bit, with the carry passed on a true rail and a
// complement rail as in the relay design. C can be gated off for increment.

`timescale 1ns/1ps
`default_nettype none

module relay_adder #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] b,
  input  logic [WIDTH-1:0] c,
  input  logic             carry_in,
  input  logic             c_enable,
  output logic [WIDTH-1:0] sum,
  output logic             carry_out
);

  logic [WIDTH-1:0] c_gated;
  logic [WIDTH:0]   carry_t;
  logic [WIDTH:0]   carry_n;

  assign c_gated    = c_enable ? c : '0;
  assign carry_t[0] = carry_in;
  assign carry_n[0] = ~carry_in;

  for (genvar i = 0; i < WIDTH; i++) begin : g_cell
    logic differ;

    assign differ = b[i] ^ c_gated[i];

    // With unequal inputs the cell passes the opposite rail through to the sum.
    assign sum[i] = differ ? carry_n[i] : carry_t[i];

    // A carry is made by two ones, or passed along when the inputs differ.
    assign carry_t[i+1] = (b[i] & c_gated[i]) | (differ & carry_t[i]);
    assign carry_n[i+1] = (~b[i] & ~c_gated[i]) | (differ & carry_n[i]);
  end

  assign carry_out = carry_t[WIDTH] & ~carry_n[WIDTH]; // Rails are complementary once settled.

endmodule

`default_nettype wire

// ==== hw/relay_logic_unit.sv ====
// Relay logic unit.
// Combinational bitwise, rotate and clear functions on the B and C operands.

`timescale 1ns/1ps
`default_nettype none

module relay_logic_unit
  import relay_alu_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] b,
  input  logic [WIDTH-1:0] c,
  input  alu_func_t        func,
  output logic [WIDTH-1:0] logic_out
);

  always_comb begin
    case (func)
      FUNC_AND: begin
        logic_out = b & c;
      end
      FUNC_OR: begin
        logic_out = b | c;
      end
      FUNC_XOR: begin
        logic_out = b ^ c;
      end
      FUNC_NOT: begin
        logic_out = ~b;
      end
      FUNC_SHL: begin
        logic_out = {b[WIDTH-2:0], b[WIDTH-1]}; // The top bit wraps round into bit 0.
      end
      FUNC_CLR: begin
        logic_out = '0;
      end
      default: begin
        logic_out = '0; // Add and increment results come from the adder.
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/relay_result_regs.sv ====
// Relay ALU register bank.
// Holds operand registers B and C, result registers A and D, and the
// zero, sign and carry condition flags.

`timescale 1ns/1ps
`default_nettype none

module relay_result_regs
  import relay_alu_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [WIDTH-1:0]    data_b,
  input  logic [WIDTH-1:0]    data_c,
  input  logic [WIDTH-1:0]    sum,
  input  logic                carry_out,
  input  logic [WIDTH-1:0]    logic_out,
  relay_alu_if.datapath       bus,
  output logic [WIDTH-1:0]    b_value,
  output logic [WIDTH-1:0]    c_value,
  output logic [WIDTH-1:0]    reg_a,
  output logic [WIDTH-1:0]    reg_d,
  output logic                flag_zero,
  output logic                flag_sign,
  output logic                flag_carry
);

  logic             use_sum;
  logic [WIDTH-1:0] result;

  assign use_sum = (bus.func == FUNC_ADD) || (bus.func == FUNC_INC);
  assign result  = use_sum ? sum : logic_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      b_value    <= '0;
      c_value    <= '0;
      reg_a      <= '0;
      reg_d      <= '0;
      flag_zero  <= 1'b0;
      flag_sign  <= 1'b0;
      flag_carry <= 1'b0;
    end else begin
      if (bus.load_ops) begin
        b_value <= data_b;
        c_value <= data_c;
      end
      if (bus.write_result) begin
        if (bus.dest_sel == DEST_A) begin
          reg_a <= result;
        end else begin
          reg_d <= result;
        end
        flag_zero  <= (result == '0);
        flag_sign  <= result[WIDTH-1];
        flag_carry <= use_sum & carry_out; // Logic functions always clear carry.
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/relay_alu_ctrl.sv ====
// Relay ALU controller.
// Runs the four-phase req/ack handshake with the host and sequences the
// operand load and result write of the datapath.

`timescale 1ns/1ps
`default_nettype none

module relay_alu_ctrl
  import relay_alu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req,
  input  alu_func_t func,
  input  alu_dest_t dest,
  output logic      ack,
  relay_alu_if.ctrl bus
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        req_sync;
  alu_func_t   func_q;
  alu_dest_t   dest_q;

  // The host request is registered once before the FSM acts on it.
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      req_sync <= 1'b0;
      func_q   <= FUNC_ADD;
      dest_q   <= DEST_A;
    end else begin
      state    <= state_next;
      req_sync <= req;
      if (state == IDLE && req_sync) begin
        func_q <= func; // Host holds func and dest stable until ack.
        dest_q <= dest;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_sync) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        state_next = WRITE;
      end
      WRITE: begin
        state_next = DONE;
      end
      DONE: begin
        if (!req_sync) begin
          state_next = IDLE; // A held request keeps ack high here.
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  assign ack              = (state == DONE);
  assign bus.load_ops     = (state == LOAD);
  assign bus.write_result = (state == WRITE);
  assign bus.func         = func_q;
  assign bus.dest_sel     = dest_q;

  // Increment is B plus a carry in of one with C held off the adder.
  assign bus.add_carry_in = (func_q == FUNC_INC);
  assign bus.c_enable     = (func_q != FUNC_INC);

endmodule

`default_nettype wire

// ==== hw/relay_alu_top.sv ====
// Relay ALU top level.
// Ties the controller, the adder, the logic unit and the register bank
// together behind the host handshake ports.

`timescale 1ns/1ps
`default_nettype none

module relay_alu_top
  import relay_alu_pkg::*;
#(
  parameter int WIDTH = WIDTH_DEFAULT
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req,
  input  alu_func_t        func,
  input  alu_dest_t        dest,
  input  logic [WIDTH-1:0] data_b,
  input  logic [WIDTH-1:0] data_c,
  output logic             ack,
  output logic [WIDTH-1:0] reg_a,
  output logic [WIDTH-1:0] reg_d,
  output logic             flag_zero,
  output logic             flag_sign,
  output logic             flag_carry
);

  logic [WIDTH-1:0] b_value;
  logic [WIDTH-1:0] c_value;
  logic [WIDTH-1:0] sum;
  logic             carry_out;
  logic [WIDTH-1:0] logic_out;

  relay_alu_if bus ();

  relay_alu_ctrl u_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .func  (func),
    .dest  (dest),
    .ack   (ack),
    .bus   (bus.ctrl)
  );

  relay_adder #(.WIDTH(WIDTH)) u_adder (
    .b         (b_value),
    .c         (c_value),
    .carry_in  (bus.add_carry_in),
    .c_enable  (bus.c_enable),
    .sum       (sum),
    .carry_out (carry_out)
  );

  relay_logic_unit #(.WIDTH(WIDTH)) u_logic (
    .b         (b_value),
    .c         (c_value),
    .func      (bus.func),
    .logic_out (logic_out)
  );

  relay_result_regs #(.WIDTH(WIDTH)) u_regs (
    .clk        (clk),
    .reset      (reset),
    .data_b     (data_b),
    .data_c     (data_c),
    .sum        (sum),
    .carry_out  (carry_out),
    .logic_out  (logic_out),
    .bus        (bus.datapath),
    .b_value    (b_value),
    .c_value    (c_value),
    .reg_a      (reg_a),
    .reg_d      (reg_d),
    .flag_zero  (flag_zero),
    .flag_sign  (flag_sign),
    .flag_carry (flag_carry)
  );

endmodule

`default_nettype wire

// ==== tb/relay_alu_assertions.sv ====
// Relay ALU handshake assertions.
// Bound to the controller to watch the four-phase req/ack protocol.

`timescale 1ns/1ps
`default_nettype none

module relay_alu_assertions (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack
);

  // ack may only answer a live request.
  ack_rise_needs_req: assert property (
    @(posedge clk) disable iff (reset) $rose(ack) |-> req
  ) else $error("ack rose while req was low");

  ack_held_until_req_falls: assert property (
    @(posedge clk) disable iff (reset) (ack && req) |=> ack
  ) else $error("ack fell before req was released");

  // The first edge of reset clears the FSM, so check from the second on.
  ack_low_in_reset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> !ack
  ) else $error("ack was high during reset");

endmodule

bind relay_alu_ctrl relay_alu_assertions u_assertions (
  .clk   (clk),
  .reset (reset),
  .req   (req),
  .ack   (ack)
);

`default_nettype wire

// ==== tb/relay_alu_tb.sv ====
// Relay ALU testbench.
// Directed tests of the add, increment and logic functions through the
// req/ack handshake, checked against a model of the function table.

`timescale 1ns/1ps
`default_nettype none

module relay_alu_tb
  import relay_alu_pkg::*;
();

  localparam int OP_TIMEOUT = 20; // Cycles allowed for ack to move.

  logic      clk;
  logic      reset;
  logic      req;
  alu_func_t func;
  alu_dest_t dest;
  alu_byte_t data_b;
  alu_byte_t data_c;
  logic      ack;
  alu_byte_t reg_a;
  alu_byte_t reg_d;
  logic      flag_zero;
  logic      flag_sign;
  logic      flag_carry;
  logic [2:0] flags;
  integer    seed;
  int        checks;
  int        errors;

  relay_alu_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .func       (func),
    .dest       (dest),
    .data_b     (data_b),
    .data_c     (data_c),
    .ack        (ack),
    .reg_a      (reg_a),
    .reg_d      (reg_d),
    .flag_zero  (flag_zero),
    .flag_sign  (flag_sign),
    .flag_carry (flag_carry)
  );

  assign flags = {flag_zero, flag_sign, flag_carry};

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s at %0t", reason, $time);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  // Expected {carry, result} of one function.
  function automatic logic [8:0] model_op(input alu_func_t f, input alu_byte_t b,
                                          input alu_byte_t c);
    case (f)
      FUNC_ADD: return {1'b0, b} + {1'b0, c};
      FUNC_INC: return {1'b0, b} + 9'd1;
      FUNC_AND: return {1'b0, b & c};
      FUNC_OR:  return {1'b0, b | c};
      FUNC_XOR: return {1'b0, b ^ c};
      FUNC_NOT: return {1'b0, ~b};
      FUNC_SHL: return {1'b0, b[6:0], b[7]};
      default:  return 9'd0;
    endcase
  endfunction

  function automatic alu_byte_t random_byte();
    return alu_byte_t'($random(seed));
  endfunction

  // One handshake. Counts edges from the edge that samples req to each ack change.
  task automatic do_op(input alu_func_t f, input alu_dest_t d, input alu_byte_t b,
                       input alu_byte_t c, input int hold, output int rise, output int fall);
    alu_byte_t  held_a;
    alu_byte_t  held_d;
    logic [2:0] held_flags;
    int         n;
    held_a     = reg_a;
    held_d     = reg_d;
    held_flags = flags;
    @(posedge clk);
    func   <= f;
    dest   <= d;
    data_b <= b;
    data_c <= c;
    req    <= 1'b1;
    @(posedge clk); // This edge samples req high.
    n    = 0;
    rise = 0;
    while (rise == 0) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (ack) begin
        rise = n;
      end else begin
        check_value("reg_a before ack", 32'(reg_a), 32'(held_a));
        check_value("reg_d before ack", 32'(reg_d), 32'(held_d));
        check_value("flags before ack", 32'(flags), 32'(held_flags));
        if (n >= OP_TIMEOUT) abort_run("Timed out waiting for ack to rise");
      end
    end
    held_a     = reg_a;
    held_d     = reg_d;
    held_flags = flags;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("ack while req held", 32'(ack), 32'd1);
      check_value("reg_a while req held", 32'(reg_a), 32'(held_a));
      check_value("reg_d while req held", 32'(reg_d), 32'(held_d));
      check_value("flags while req held", 32'(flags), 32'(held_flags));
    end
    @(posedge clk);
    req <= 1'b0;
    @(posedge clk);
    n    = 0;
    fall = 0;
    while (fall == 0) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (!ack) begin
        fall = n;
      end else if (n >= OP_TIMEOUT) begin
        abort_run("Timed out waiting for ack to fall");
      end
    end
  endtask

  task automatic run_and_check(input alu_func_t f, input alu_dest_t d, input alu_byte_t b,
                               input alu_byte_t c, input int hold);
    logic [8:0] model;
    alu_byte_t  old_a;
    alu_byte_t  old_d;
    int         rise;
    int         fall;
    model = model_op(f, b, c);
    old_a = reg_a;
    old_d = reg_d;
    do_op(f, d, b, c, hold, rise, fall);
    check_value("ack rise cycles", 32'(rise), 32'd3);
    check_value("ack fall cycles", 32'(fall), 32'd1);
    check_value("reg_a", 32'(reg_a), (d == DEST_A) ? 32'(model[7:0]) : 32'(old_a));
    check_value("reg_d", 32'(reg_d), (d == DEST_D) ? 32'(model[7:0]) : 32'(old_d));
    check_value("flag_zero", 32'(flag_zero), 32'(model[7:0] == 8'h00));
    check_value("flag_sign", 32'(flag_sign), 32'(model[7]));
    check_value("flag_carry", 32'(flag_carry), 32'(model[8]));
  endtask

  task automatic test_reset();
    check_value("ack", 32'(ack), 32'd0);
    check_value("reg_a", 32'(reg_a), 32'd0);
    check_value("reg_d", 32'(reg_d), 32'd0);
    check_value("flag_zero", 32'(flag_zero), 32'd0);
    check_value("flag_sign", 32'(flag_sign), 32'd0);
    check_value("flag_carry", 32'(flag_carry), 32'd0);
  endtask

  task automatic test_add();
    run_and_check(FUNC_ADD, DEST_A, 8'h3C, 8'h05, 0);
    check_value("reg_a for 3C plus 05", 32'(reg_a), 32'h41);
    run_and_check(FUNC_ADD, DEST_A, 8'hFF, 8'h01, 0);
    check_value("flag_carry for FF plus 01", 32'(flag_carry), 32'd1);
    for (int i = 0; i < 20; i++) begin
      run_and_check(FUNC_ADD, DEST_A, random_byte(), random_byte(), 0);
    end
  endtask

  task automatic test_inc();
    run_and_check(FUNC_INC, DEST_A, 8'h7F, random_byte(), 0); // C must not reach the adder.
    check_value("reg_a for 7F plus 1", 32'(reg_a), 32'h80);
  endtask

  task automatic test_logic_to_d();
    for (int k = 2; k < 8; k++) begin
      run_and_check(alu_func_t'(3'(k)), DEST_D, random_byte(), random_byte(), 0);
    end
  endtask

  task automatic test_held_req();
    run_and_check(FUNC_XOR, DEST_D, random_byte(), random_byte(), 10);
  endtask

  initial begin
    seed   = 32'h9cb63132;
    checks = 0;
    errors = 0;
    clk    = 1'b0;
    reset  = 1'b1;
    req    = 1'b0;
    func   = FUNC_ADD;
    dest   = DEST_A;
    data_b = '0;
    data_c = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset();
    test_add();
    test_inc();
    test_logic_to_d();
    test_held_req();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/relay_alu_pkg.sv
hw/relay_alu_if.sv
hw/relay_adder.sv
hw/relay_logic_unit.sv
hw/relay_result_regs.sv
hw/relay_alu_ctrl.sv
hw/relay_alu_top.sv
tb/relay_alu_assertions.sv
tb/relay_alu_tb.sv

// ==== Makefile ====
TOP := relay_alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then \
	  echo "Simulation reported failure"; \
	  exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
